/* hdl/warp_issue_pkg.sv */
package warp_issue_pkg;

    localparam int NUM_WARPS  = 4;
    localparam int WID_W      = 2;
    localparam int IBUF_DEPTH = 4;
    localparam int NUM_REGS   = 16;
    localparam int REG_W      = 4;
    localparam int XLEN       = 16;
    localparam int INSTR_W    = 23;

    localparam int OP_W   = 3;
    localparam int IMM_W  = INSTR_W - OP_W - 2 * REG_W;
    localparam int PAD_W  = INSTR_W - OP_W - 3 * REG_W;
    localparam int QPTR_W = $clog2(IBUF_DEPTH);
    localparam int QCNT_W = $clog2(IBUF_DEPTH + 1);

    typedef enum logic [OP_W-1:0] {
        OP_ADD  = 3'd0,
        OP_SUB  = 3'd1,
        OP_AND  = 3'd2,
        OP_OR   = 3'd3,
        OP_XOR  = 3'd4,
        OP_SLT  = 3'd5,
        OP_ADDI = 3'd6,
        OP_ANDI = 3'd7
    } op_e;

    // --------------------
    // Instruction word views.
    typedef struct packed {
        op_e              op;
        logic [REG_W-1:0] rd;
        logic [REG_W-1:0] rs1;
        logic [REG_W-1:0] rs2;
        logic [PAD_W-1:0] pad;
    } instr_r_t;

    typedef struct packed {
        op_e              op;
        logic [REG_W-1:0] rd;
        logic [REG_W-1:0] rs1;
        logic [IMM_W-1:0] imm;
    } instr_i_t;

    typedef union packed {
        instr_r_t r;
        instr_i_t i;
    } instr_word_u;

    // --------------------
    // Stage records.
    typedef struct packed {
        logic [WID_W-1:0]   wid;
        logic [INSTR_W-1:0] word;
    } fetch_t;

    typedef struct packed {
        logic [WID_W-1:0] wid;
        op_e              op;
        logic [REG_W-1:0] rd;
        logic [REG_W-1:0] rs1;
        logic [REG_W-1:0] rs2;
        logic             use_imm;
        logic [XLEN-1:0]  imm;
    } dec_instr_t;

    typedef struct packed {
        logic [WID_W-1:0] wid;
        logic [REG_W-1:0] rd;
        logic [XLEN-1:0]  value;
    } exe_t;

    typedef struct packed {
        logic [WID_W-1:0] wid;
        logic [REG_W-1:0] rd;
        logic [XLEN-1:0]  value;
    } result_t;

endpackage

/* hdl/warp_decode.sv */
`timescale 1ns/10ps

module warp_decode
    import warp_issue_pkg::*;
(
    input  logic       clk,
    input  logic       reset,

    input  logic       fetch_valid,
    output logic       fetch_ready,
    input  fetch_t     fetch,

    output logic       dec_valid,
    input  logic       dec_ready,
    output dec_instr_t dec
);

    instr_word_u word;
    dec_instr_t  dec_next;
    logic        fetch_fire;

    assign word = fetch.word;

    // --------------------
    // Field select by opcode.
    always_comb begin
        dec_next.wid = fetch.wid;
        dec_next.op  = word.r.op;
        dec_next.rd  = word.r.rd;
        dec_next.rs1 = word.r.rs1;
        case (word.r.op)
            OP_ADDI, OP_ANDI: begin
                dec_next.use_imm = 1'b1;
                dec_next.rs2     = '0;
                dec_next.imm     = {{(XLEN-IMM_W){word.i.imm[IMM_W-1]}}, word.i.imm};
            end
            default: begin
                dec_next.use_imm = 1'b0;
                dec_next.rs2     = word.r.rs2;
                dec_next.imm     = '0;
            end
        endcase
    end

    // Output register, refilled while it drains.
    assign fetch_ready = !dec_valid || dec_ready;
    assign fetch_fire  = fetch_valid && fetch_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            dec_valid <= 1'b0;
        end else if (fetch_fire) begin
            dec_valid <= 1'b1;
        end else if (dec_ready) begin
            dec_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (fetch_fire) begin
            dec <= dec_next;
        end
    end

endmodule

/* hdl/warp_ibuffer.sv */
`timescale 1ns/10ps

module warp_ibuffer
    import warp_issue_pkg::*;
(
    input  logic                              clk,
    input  logic                              reset,

    input  logic                              dec_valid,
    output logic                              dec_ready,
    input  dec_instr_t                        dec,

    output logic [NUM_WARPS-1:0]              head_valid,
    output logic [NUM_WARPS-1:0][REG_W-1:0]   head_rd,
    output logic [NUM_WARPS-1:0][REG_W-1:0]   head_rs1,
    output logic [NUM_WARPS-1:0][REG_W-1:0]   head_rs2,
    input  logic [NUM_WARPS-1:0]              sb_ready,

    output logic                              iss_valid,
    input  logic                              iss_ready,
    output dec_instr_t                        iss
);

    dec_instr_t                      q_mem [NUM_WARPS][IBUF_DEPTH];
    dec_instr_t                      head  [NUM_WARPS];
    logic [NUM_WARPS-1:0][QPTR_W-1:0] wr_ptr;
    logic [NUM_WARPS-1:0][QPTR_W-1:0] rd_ptr;
    logic [NUM_WARPS-1:0][QCNT_W-1:0] q_count;
    logic [NUM_WARPS-1:0]             q_full;
    logic [NUM_WARPS-1:0]             push_en;
    logic [NUM_WARPS-1:0]             pop_en;
    logic [NUM_WARPS-1:0]             eligible;

    logic             out_free;
    logic             grant_valid;
    logic [WID_W-1:0] grant_wid;
    logic [WID_W-1:0] last_wid;
    logic [WID_W-1:0] cand;

    assign dec_ready = !q_full[dec.wid];
    assign out_free  = !iss_valid || iss_ready;

    // --------------------
    // Per-warp queue state.
    for (genvar w = 0; w < NUM_WARPS; w++) begin : g_queue
        assign head[w]       = q_mem[w][rd_ptr[w]];
        assign q_full[w]     = (q_count[w] == QCNT_W'(IBUF_DEPTH));
        assign head_valid[w] = (q_count[w] != '0);
        assign head_rd[w]    = head[w].rd;
        assign head_rs1[w]   = head[w].rs1;
        assign head_rs2[w]   = head[w].rs2;
        assign eligible[w]   = head_valid[w] && sb_ready[w];
        assign push_en[w]    = dec_valid && dec_ready && (dec.wid == WID_W'(w));
        assign pop_en[w]     = out_free && grant_valid && (grant_wid == WID_W'(w));

        a_count_bound: assert property (@(posedge clk) disable iff (reset)
            q_count[w] <= QCNT_W'(IBUF_DEPTH));
    end

    always_ff @(posedge clk) begin
        for (int w = 0; w < NUM_WARPS; w++) begin
            if (push_en[w]) begin
                q_mem[w][wr_ptr[w]] <= dec;
            end
        end
    end

    // --------------------
    // Round-robin select, starting after the last issuer.
    always_comb begin
        grant_valid = 1'b0;
        grant_wid   = '0;
        cand        = '0;
        for (int i = 1; i <= NUM_WARPS; i++) begin
            cand = last_wid + WID_W'(i);
            if (!grant_valid && eligible[cand]) begin
                grant_valid = 1'b1;
                grant_wid   = cand;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr    <= '0;
            rd_ptr    <= '0;
            q_count   <= '0;
            iss_valid <= 1'b0;
            last_wid  <= '0;
        end else begin
            for (int w = 0; w < NUM_WARPS; w++) begin
                if (push_en[w]) begin
                    wr_ptr[w] <= wr_ptr[w] + 1'b1;
                end
                if (pop_en[w]) begin
                    rd_ptr[w] <= rd_ptr[w] + 1'b1;
                end
                q_count[w] <= q_count[w] + QCNT_W'(push_en[w]) - QCNT_W'(pop_en[w]);
            end
            if (out_free) begin
                iss_valid <= grant_valid;
                if (grant_valid) begin
                    last_wid <= grant_wid;
                end
            end
        end
    end

    // Issue payload register.
    always_ff @(posedge clk) begin
        if (out_free && grant_valid) begin
            iss <= head[grant_wid];
        end
    end

    a_iss_hold: assert property (@(posedge clk) disable iff (reset)
        iss_valid && !iss_ready |=> iss_valid && $stable(iss));

endmodule

/* hdl/warp_scoreboard.sv */
`timescale 1ns/10ps

module warp_scoreboard
    import warp_issue_pkg::*;
(
    input  logic                            clk,
    input  logic                            reset,

    input  logic                            iss_valid,
    input  logic                            iss_ready,
    input  dec_instr_t                      iss,

    input  logic [NUM_WARPS-1:0]            head_valid,
    input  logic [NUM_WARPS-1:0][REG_W-1:0] head_rd,
    input  logic [NUM_WARPS-1:0][REG_W-1:0] head_rs1,
    input  logic [NUM_WARPS-1:0][REG_W-1:0] head_rs2,
    output logic [NUM_WARPS-1:0]            sb_ready,

    input  logic                            clr_valid,
    input  exe_t                            clr
);

    logic [NUM_WARPS-1:0][NUM_REGS-1:0] pending;
    logic                               set_en;
    logic                               clr_en;

    // Register 0 never gets a pending bit.
    assign set_en = iss_valid && iss_ready && (iss.rd != '0);
    assign clr_en = clr_valid && (clr.rd != '0);

    always_ff @(posedge clk) begin
        if (reset) begin
            pending <= '0;
        end else begin
            if (set_en) begin
                pending[iss.wid][iss.rd] <= 1'b1;
            end
            if (clr_en) begin
                pending[clr.wid][clr.rd] <= 1'b0;
            end
        end
    end

    // --------------------
    // Hazard check per warp head.
    // The held issue slot counts as pending too.
    for (genvar w = 0; w < NUM_WARPS; w++) begin : g_ready
        logic busy_regs;
        logic busy_iss;

        assign busy_regs = pending[w][head_rd[w]] || pending[w][head_rs1[w]]
                        || pending[w][head_rs2[w]];
        assign busy_iss  = iss_valid && (iss.wid == WID_W'(w)) && (iss.rd != '0)
                        && (iss.rd == head_rd[w] || iss.rd == head_rs1[w]
                            || iss.rd == head_rs2[w]);
        assign sb_ready[w] = head_valid[w] && !busy_regs && !busy_iss;
    end

    a_set_free: assert property (@(posedge clk) disable iff (reset)
        set_en |-> !pending[iss.wid][iss.rd]);

    a_clr_held: assert property (@(posedge clk) disable iff (reset)
        clr_en |-> pending[clr.wid][clr.rd]);

endmodule

/* hdl/warp_execute.sv */
`timescale 1ns/10ps

module warp_execute
    import warp_issue_pkg::*;
(
    input  logic             clk,
    input  logic             reset,

    input  logic             iss_valid,
    output logic             iss_ready,
    input  dec_instr_t       iss,

    output logic [WID_W-1:0] rd_wid,
    output logic [REG_W-1:0] rd_rs1,
    output logic [REG_W-1:0] rd_rs2,
    input  logic [XLEN-1:0]  rd_data1,
    input  logic [XLEN-1:0]  rd_data2,

    output logic             exe_valid,
    input  logic             exe_ready,
    output exe_t             exe
);

    logic [XLEN-1:0] op_b;
    logic [XLEN-1:0] alu_out;
    logic            iss_fire;

    // Operand read.
    assign rd_wid = iss.wid;
    assign rd_rs1 = iss.rs1;
    assign rd_rs2 = iss.rs2;

    // --------------------
    // ALU.
    always_comb begin
        op_b = iss.use_imm ? iss.imm : rd_data2;
        case (iss.op)
            OP_ADD, OP_ADDI: alu_out = rd_data1 + op_b;
            OP_SUB:          alu_out = rd_data1 - op_b;
            OP_AND, OP_ANDI: alu_out = rd_data1 & op_b;
            OP_OR:           alu_out = rd_data1 | op_b;
            OP_XOR:          alu_out = rd_data1 ^ op_b;
            OP_SLT:          alu_out = {{(XLEN-1){1'b0}}, $signed(rd_data1) < $signed(op_b)};
            default:         alu_out = '0;
        endcase
    end

    assign iss_ready = !exe_valid || exe_ready;
    assign iss_fire  = iss_valid && iss_ready;

    always_ff @(posedge clk) begin
        if (reset) begin
            exe_valid <= 1'b0;
        end else if (iss_fire) begin
            exe_valid <= 1'b1;
        end else if (exe_ready) begin
            exe_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (iss_fire) begin
            exe.wid   <= iss.wid;
            exe.rd    <= iss.rd;
            exe.value <= alu_out;
        end
    end

endmodule

/* hdl/warp_result.sv */
`timescale 1ns/10ps

module warp_result
    import warp_issue_pkg::*;
(
    input  logic             clk,
    input  logic             reset,

    input  logic [WID_W-1:0] rd_wid,
    input  logic [REG_W-1:0] rd_rs1,
    input  logic [REG_W-1:0] rd_rs2,
    output logic [XLEN-1:0]  rd_data1,
    output logic [XLEN-1:0]  rd_data2,

    input  logic             exe_valid,
    output logic             exe_ready,
    input  exe_t             exe,

    output logic             res_valid,
    input  logic             res_ready,
    output result_t          res,

    output logic             clr_valid,
    output exe_t             clr
);

    logic [NUM_WARPS-1:0][NUM_REGS-1:0][XLEN-1:0] regs;
    logic                                         exe_fire;
    logic                                         res_fire;

    assign exe_ready = !res_valid || res_ready;
    assign exe_fire  = exe_valid && exe_ready;
    assign res_fire  = res_valid && res_ready;

    // --------------------
    // Register file, r0 hardwired to zero.
    assign rd_data1 = (rd_rs1 == '0) ? '0 : regs[rd_wid][rd_rs1];
    assign rd_data2 = (rd_rs2 == '0) ? '0 : regs[rd_wid][rd_rs2];

    always_ff @(posedge clk) begin
        if (reset) begin
            regs <= '0;
        end else if (res_fire && res.rd != '0) begin
            regs[res.wid][res.rd] <= res.value;
        end
    end

    // --------------------
    // One-entry output stage.
    always_ff @(posedge clk) begin
        if (reset) begin
            res_valid <= 1'b0;
        end else if (exe_fire) begin
            res_valid <= 1'b1;
        end else if (res_ready) begin
            res_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (exe_fire) begin
            res.wid   <= exe.wid;
            res.rd    <= exe.rd;
            res.value <= exe.value;
        end
    end

    // Release the scoreboard entry with the writeback.
    assign clr_valid = res_fire;
    assign clr.wid   = res.wid;
    assign clr.rd    = res.rd;
    assign clr.value = res.value;

endmodule

/* hdl/warp_issue_top.sv */
`timescale 1ns/10ps

module warp_issue_top
    import warp_issue_pkg::*;
(
    input  logic    clk,
    input  logic    reset,

    input  logic    fetch_valid,
    output logic    fetch_ready,
    input  fetch_t  fetch,

    output logic    res_valid,
    input  logic    res_ready,
    output result_t res
);

    logic                            dec_valid;
    logic                            dec_ready;
    dec_instr_t                      dec;
    logic [NUM_WARPS-1:0]            head_valid;
    logic [NUM_WARPS-1:0][REG_W-1:0] head_rd;
    logic [NUM_WARPS-1:0][REG_W-1:0] head_rs1;
    logic [NUM_WARPS-1:0][REG_W-1:0] head_rs2;
    logic [NUM_WARPS-1:0]            sb_ready;
    logic                            iss_valid;
    logic                            iss_ready;
    dec_instr_t                      iss;
    logic [WID_W-1:0]                rd_wid;
    logic [REG_W-1:0]                rd_rs1;
    logic [REG_W-1:0]                rd_rs2;
    logic [XLEN-1:0]                 rd_data1;
    logic [XLEN-1:0]                 rd_data2;
    logic                            exe_valid;
    logic                            exe_ready;
    exe_t                            exe;
    logic                            clr_valid;
    exe_t                            clr;

    warp_decode decode0 (
        .clk         (clk),
        .reset       (reset),
        .fetch_valid (fetch_valid),
        .fetch_ready (fetch_ready),
        .fetch       (fetch),
        .dec_valid   (dec_valid),
        .dec_ready   (dec_ready),
        .dec         (dec)
    );

    warp_ibuffer ibuffer0 (
        .clk        (clk),
        .reset      (reset),
        .dec_valid  (dec_valid),
        .dec_ready  (dec_ready),
        .dec        (dec),
        .head_valid (head_valid),
        .head_rd    (head_rd),
        .head_rs1   (head_rs1),
        .head_rs2   (head_rs2),
        .sb_ready   (sb_ready),
        .iss_valid  (iss_valid),
        .iss_ready  (iss_ready),
        .iss        (iss)
    );

    warp_scoreboard scoreboard0 (
        .clk        (clk),
        .reset      (reset),
        .iss_valid  (iss_valid),
        .iss_ready  (iss_ready),
        .iss        (iss),
        .head_valid (head_valid),
        .head_rd    (head_rd),
        .head_rs1   (head_rs1),
        .head_rs2   (head_rs2),
        .sb_ready   (sb_ready),
        .clr_valid  (clr_valid),
        .clr        (clr)
    );

    warp_execute execute0 (
        .clk       (clk),
        .reset     (reset),
        .iss_valid (iss_valid),
        .iss_ready (iss_ready),
        .iss       (iss),
        .rd_wid    (rd_wid),
        .rd_rs1    (rd_rs1),
        .rd_rs2    (rd_rs2),
        .rd_data1  (rd_data1),
        .rd_data2  (rd_data2),
        .exe_valid (exe_valid),
        .exe_ready (exe_ready),
        .exe       (exe)
    );

    warp_result result0 (
        .clk       (clk),
        .reset     (reset),
        .rd_wid    (rd_wid),
        .rd_rs1    (rd_rs1),
        .rd_rs2    (rd_rs2),
        .rd_data1  (rd_data1),
        .rd_data2  (rd_data2),
        .exe_valid (exe_valid),
        .exe_ready (exe_ready),
        .exe       (exe),
        .res_valid (res_valid),
        .res_ready (res_ready),
        .res       (res),
        .clr_valid (clr_valid),
        .clr       (clr)
    );

endmodule

/* test/warp_issue_checker.sv */
`timescale 1ns/10ps

module warp_issue_checker
    import warp_issue_pkg::*;
(
    input  logic    clk,
    input  logic    reset,
    input  logic    fetch_valid,
    input  logic    fetch_ready,
    input  fetch_t  fetch,
    input  logic    res_valid,
    input  logic    res_ready,
    input  result_t res,
    output int      acc_count,
    output int      res_count,
    output int      pass_count,
    output int      err_count,
    output int      drop_count
);

    localparam int PEND_DEPTH = 32;

    string              test_name = "none";
    logic [XLEN-1:0]    model_regs [NUM_WARPS][NUM_REGS];
    logic [INSTR_W-1:0] pend       [NUM_WARPS][PEND_DEPTH];
    int                 pend_head  [NUM_WARPS];
    int                 pend_cnt   [NUM_WARPS];
    logic [WID_W-1:0]   last_wid;

    initial begin
        acc_count  = 0;
        res_count  = 0;
        pass_count = 0;
        err_count  = 0;
        drop_count = 0;
        last_wid   = '0;
        for (int w = 0; w < NUM_WARPS; w++) begin
            pend_head[w] = 0;
            pend_cnt[w]  = 0;
            for (int r = 0; r < NUM_REGS; r++) begin
                model_regs[w][r] = '0;
            end
        end
    end

    // Opcode rules.
    function automatic logic [XLEN-1:0] expect_value(input logic [2:0] op,
                                                     input logic [XLEN-1:0] a,
                                                     input logic [XLEN-1:0] b);
        case (op)
            OP_ADD, OP_ADDI: return a + b;
            OP_SUB:          return a - b;
            OP_AND, OP_ANDI: return a & b;
            OP_OR:           return a | b;
            OP_XOR:          return a ^ b;
            OP_SLT:          return ($signed(a) < $signed(b)) ? XLEN'(1) : '0;
            default:         return '0;
        endcase
    endfunction

    task automatic record_fetch();
        int w;
        w = fetch.wid;
        last_wid = fetch.wid;
        if (pend_cnt[w] == PEND_DEPTH) begin
            $display("%s: model queue of warp %0d overflowed", test_name, w);
            err_count++;
        end else begin
            pend[w][(pend_head[w] + pend_cnt[w]) % PEND_DEPTH] = fetch.word;
            pend_cnt[w]++;
        end
        acc_count++;
    endtask

    // --------------------
    task automatic check_result();
        int                 w;
        logic [INSTR_W-1:0] word;
        logic [2:0]         op;
        logic [REG_W-1:0]   rd;
        logic [REG_W-1:0]   rs1;
        logic [REG_W-1:0]   rs2;
        logic [XLEN-1:0]    a;
        logic [XLEN-1:0]    b;
        logic [XLEN-1:0]    expected;
        w = res.wid;
        res_count++;
        if (pend_cnt[w] == 0) begin
            $display("%s: result on warp %0d with no outstanding instruction", test_name, w);
            err_count++;
        end else begin
            word = pend[w][pend_head[w]];
            pend_head[w] = (pend_head[w] + 1) % PEND_DEPTH;
            pend_cnt[w]--;
            op  = word[22:20];
            rd  = word[19:16];
            rs1 = word[15:12];
            rs2 = word[11:8];
            a = (rs1 == '0) ? '0 : model_regs[w][rs1];
            if (op == OP_ADDI || op == OP_ANDI) begin
                b = {{(XLEN-12){word[11]}}, word[11:0]};
            end else begin
                b = (rs2 == '0) ? '0 : model_regs[w][rs2];
            end
            expected = expect_value(op, a, b);
            if (res.rd !== rd) begin
                $display("ERR %s warp %0d rd expected %0d actual %0d",
                         test_name, w, rd, res.rd);
                err_count++;
            end else if (res.value !== expected) begin
                $display("ERR %s warp %0d value expected %h actual %h",
                         test_name, w, expected, res.value);
                err_count++;
            end else begin
                pass_count++;
            end
            // r0 stays zero
            if (rd != '0) begin
                model_regs[w][rd] = expected;
            end
        end
    endtask

    // A stalled fetch means decode holds one word and its warp queue is full.
    task automatic check_stall();
        drop_count++;
        if (pend_cnt[last_wid] < IBUF_DEPTH) begin
            $display("%s: fetch_ready low while warp %0d has only %0d instructions outstanding",
                     test_name, last_wid, pend_cnt[last_wid]);
            err_count++;
        end
    endtask

    // Mid-cycle sampling.
    always @(negedge clk) begin
        if (reset === 1'b0) begin
            if (res_valid === 1'b1 && res_ready === 1'b1) begin
                check_result();
            end
            if (fetch_valid === 1'b1 && fetch_ready === 1'b1) begin
                record_fetch();
            end
            if (fetch_ready === 1'b0) begin
                check_stall();
            end
        end
    end

endmodule

/* test/warp_issue_tb.sv */
`timescale 1ns/10ps

module warp_issue_tb
    import warp_issue_pkg::*;
();

    localparam int READY_HIGH     = 1;
    localparam int READY_RANDOM   = 2;
    localparam int KIND_CHAIN     = 0;
    localparam int KIND_MIXED     = 1;
    localparam int KIND_IMM       = 2;
    localparam int ACCEPT_TIMEOUT = 500;
    localparam int DRAIN_TIMEOUT  = 2000;

    logic        clk;
    logic        reset;
    logic        fetch_valid;
    logic        fetch_ready;
    fetch_t      fetch;
    logic        res_valid;
    logic        res_ready;
    result_t     res;
    int          acc_count;
    int          res_count;
    int          pass_count;
    int          err_count;
    int          drop_count;
    int unsigned stim_state  = 10;
    int unsigned ready_state = 10;
    int          ready_mode  = READY_HIGH;
    int          tb_errors   = 0;
    int          tb_passes   = 0;
    bit          aborted     = 1'b0;

    warp_issue_top dut0 (
        .clk         (clk),
        .reset       (reset),
        .fetch_valid (fetch_valid),
        .fetch_ready (fetch_ready),
        .fetch       (fetch),
        .res_valid   (res_valid),
        .res_ready   (res_ready),
        .res         (res)
    );

    warp_issue_checker checker0 (
        .clk         (clk),
        .reset       (reset),
        .fetch_valid (fetch_valid),
        .fetch_ready (fetch_ready),
        .fetch       (fetch),
        .res_valid   (res_valid),
        .res_ready   (res_ready),
        .res         (res),
        .acc_count   (acc_count),
        .res_count   (res_count),
        .pass_count  (pass_count),
        .err_count   (err_count),
        .drop_count  (drop_count)
    );

    always #50 clk = ~clk;

    function automatic int unsigned lcg_step(inout int unsigned state);
        state = state * 32'd1103515245 + 32'd12345;
        return state >> 8;
    endfunction

    function automatic int unsigned pick(input int unsigned n);
        return lcg_step(stim_state) % n;
    endfunction

    // Result stream back-pressure.
    always @(posedge clk) begin
        if (ready_mode == READY_RANDOM) begin
            res_ready <= (lcg_step(ready_state) % 8) < 3;
        end else begin
            res_ready <= 1'b1;
        end
    end

    // --------------------
    task automatic gen_instr(input int kind, output logic [WID_W-1:0] wid,
                             output logic [INSTR_W-1:0] word);
        op_e              op;
        logic [REG_W-1:0] rd;
        logic [REG_W-1:0] rs1;
        logic [REG_W-1:0] rs2;
        logic [11:0]      low;
        op  = op_e'(pick(8));
        wid = WID_W'(pick(NUM_WARPS));
        rd  = REG_W'(pick(NUM_REGS));
        rs1 = REG_W'(pick(NUM_REGS));
        rs2 = REG_W'(pick(NUM_REGS));
        low = 12'(pick(4096));
        case (kind)
            KIND_CHAIN: begin
                wid = '0;
                rd  = REG_W'(1 + pick(3));
                rs1 = REG_W'(1 + pick(3));
                rs2 = REG_W'(1 + pick(3));
            end
            KIND_IMM: begin
                case (pick(4))
                    0:       op = OP_ADDI;
                    1:       op = OP_ANDI;
                    2:       op = OP_ADD;
                    default: op = OP_SLT;
                endcase
                rd  = (pick(3) == 0) ? '0 : REG_W'(pick(4));
                rs1 = REG_W'(pick(4));
                rs2 = REG_W'(pick(4));
                low[11] = 1'b1;
            end
            default: begin
            end
        endcase
        // R-format keeps random pad bits.
        if (op != OP_ADDI && op != OP_ANDI) begin
            low[11:8] = rs2;
        end
        word = {op, rd, rs1, low};
    endtask

    task automatic wait_accept(input string name);
        int waited;
        waited = 0;
        @(posedge clk);
        while (fetch_ready !== 1'b1 && waited < ACCEPT_TIMEOUT) begin
            waited++;
            @(posedge clk);
        end
        if (fetch_ready !== 1'b1) begin
            $display("%s: fetch not accepted within %0d cycles", name, ACCEPT_TIMEOUT);
            tb_errors++;
            aborted = 1'b1;
        end
    endtask

    task automatic drain(input string name);
        int waited;
        waited = 0;
        @(posedge clk);
        while (res_count != acc_count && waited < DRAIN_TIMEOUT) begin
            waited++;
            @(posedge clk);
        end
        if (res_count != acc_count) begin
            $display("%s: %0d instructions without a result after %0d cycles",
                     name, acc_count - res_count, DRAIN_TIMEOUT);
            tb_errors++;
            aborted = 1'b1;
        end
    endtask

    task automatic check_count(input string name, input string what,
                               input int expected, input int actual);
        if (expected != actual) begin
            $display("ERR %s %s expected %0d actual %0d", name, what, expected, actual);
            tb_errors++;
        end else begin
            tb_passes++;
        end
    endtask

    task automatic report_test(input string name, input int results, input int err0);
        int errs;
        errs = tb_errors + err_count - err0;
        $display("test %s: %0d results, %0d errors, %s",
                 name, results, errs, (errs == 0) ? "ok" : "failed");
    endtask

    // --------------------
    task automatic check_reset_state();
        int err0;
        err0 = tb_errors + err_count;
        checker0.test_name = "reset_state";
        for (int cyc = 0; cyc < 8; cyc++) begin
            @(posedge clk);
            check_count("reset_state", "fetch_ready", 1, int'(fetch_ready === 1'b1));
            check_count("reset_state", "res_valid", 0, int'(res_valid !== 1'b0));
        end
        report_test("reset_state", 0, err0);
    endtask

    task automatic run_stream(input string name, input int count, input int kind,
                              input bit gaps, input bit need_stall);
        logic [WID_W-1:0]   wid;
        logic [INSTR_W-1:0] word;
        int                 acc0;
        int                 res0;
        int                 err0;
        int                 drop0;
        int                 gap;
        acc0  = acc_count;
        res0  = res_count;
        err0  = tb_errors + err_count;
        drop0 = drop_count;
        checker0.test_name = name;
        for (int n = 0; n < count && !aborted; n++) begin
            gen_instr(kind, wid, word);
            gap = gaps ? int'(pick(3)) : 0;
            if (gap > 0) begin
                fetch_valid <= 1'b0;
                repeat (gap) @(posedge clk);
            end
            fetch_valid <= 1'b1;
            fetch.wid   <= wid;
            fetch.word  <= word;
            wait_accept(name);
        end
        fetch_valid <= 1'b0;
        if (!aborted) begin
            drain(name);
        end
        if (!aborted) begin
            check_count(name, "accepted", count, acc_count - acc0);
        end
        if (need_stall && drop_count == drop0) begin
            $display("%s: fetch_ready never dropped under back-pressure", name);
            tb_errors++;
        end
        report_test(name, res_count - res0, err0);
    endtask

    initial begin
        clk         = 1'b0;
        reset       = 1'b1;
        fetch_valid = 1'b0;
        fetch       = '0;
        res_ready   = 1'b0;
        repeat (5) @(posedge clk);
        reset <= 1'b0;

        check_reset_state();
        run_stream("single_warp_chain", 40, KIND_CHAIN, 1'b0, 1'b0);
        run_stream("all_warps", 200, KIND_MIXED, 1'b1, 1'b0);
        ready_mode <= READY_RANDOM;
        run_stream("back_pressure", 200, KIND_MIXED, 1'b0, 1'b1);
        ready_mode <= READY_HIGH;
        run_stream("imm_and_r0", 60, KIND_IMM, 1'b1, 1'b0);

        $display("checks passed %0d, errors %0d", tb_passes + pass_count, tb_errors + err_count);
        if (tb_errors + err_count == 0) begin
            $display("*** TEST PASSED ***");
        end else begin
            $display("*** TEST FAILED ***");
        end
        $finish;
    end

endmodule

/* warp_issue.f */
hdl/warp_issue_pkg.sv
hdl/warp_decode.sv
hdl/warp_ibuffer.sv
hdl/warp_scoreboard.sv
hdl/warp_execute.sv
hdl/warp_result.sv
hdl/warp_issue_top.sv
test/warp_issue_checker.sv
test/warp_issue_tb.sv
